/* fetch_pkg.sv */
package fetch_pkg;

  // Address and instruction widths.
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // Bytes per instruction and the matching byte-offset width.
  localparam int inst_bytes = data_w / 8;
  localparam int offset_w = $clog2(inst_bytes);

  // Packet handed to decode.
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [data_w-1:0] inst;
  } fetch_pkt_t;

  // Lookup request, seen by the cache and the bus fetcher.
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] addr;
  } lookup_req_t;

  // Word returned by the bus.
  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } fill_t;

endpackage

/* l1i_cache.sv */
`timescale 1ns/1ps

module l1i_cache #(
  parameter int SETS = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  fetch_pkg::lookup_req_t        req_i,
  input  fetch_pkg::fill_t              fill_i,
  output logic                          hit_o,
  output logic [fetch_pkg::data_w-1:0]  hit_data_o
);
  import fetch_pkg::*;

  localparam int index_w = $clog2(SETS);
  localparam int tag_w = addr_w - index_w - offset_w;

  logic [data_w-1:0] data_mem [SETS];
  logic [tag_w-1:0]  tag_mem [SETS];
  logic [SETS-1:0]   valid_q;

  logic [index_w-1:0] req_index;
  logic [tag_w-1:0]   req_tag;
  logic [index_w-1:0] fill_index;
  logic [tag_w-1:0]   fill_tag;

  // Address split: tag, index, word offset (offset ignored).
  assign req_index = req_i.addr[offset_w +: index_w];
  assign req_tag = req_i.addr[addr_w-1 -: tag_w];
  assign fill_index = fill_i.addr[offset_w +: index_w];
  assign fill_tag = fill_i.addr[addr_w-1 -: tag_w];

  // Combinational lookup.
  assign hit_o = req_i.valid & valid_q[req_index] & (tag_mem[req_index] == req_tag);
  assign hit_data_o = data_mem[req_index];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (fill_i.valid)
    begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  // Line payload written on every fill, stale or live.
  always_ff @(posedge clk)
  begin
    if (fill_i.valid)
    begin
      data_mem[fill_index] <= fill_i.data;
      tag_mem[fill_index] <= fill_tag;
    end
  end

endmodule

/* bus_fetcher.sv */
`timescale 1ns/1ps

module bus_fetcher (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          miss_i,
  input  logic [fetch_pkg::addr_w-1:0]  miss_addr_i,
  input  logic                          flush_i,
  output logic                          ar_valid_o,
  output logic [fetch_pkg::addr_w-1:0]  ar_addr_o,
  input  logic                          ar_ready_i,
  input  logic                          r_valid_i,
  input  logic [fetch_pkg::data_w-1:0]  r_data_i,
  output fetch_pkg::fill_t              fill_o,
  output logic                          fill_live_o
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_wait
  } state_t;

  state_t            state_q;
  logic              stale_q;
  logic [addr_w-1:0] addr_q;

  assign ar_valid_o = (state_q == st_addr);
  assign ar_addr_o = addr_q;

  // Fill is seen the same cycle the data returns.
  assign fill_o.valid = (state_q == st_wait) & r_valid_i;
  assign fill_o.addr = addr_q;
  assign fill_o.data = r_data_i;
  assign fill_live_o = fill_o.valid & ~stale_q & ~flush_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= st_idle;
      stale_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        st_idle:
        begin
          if (miss_i)
          begin
            state_q <= st_addr;
            stale_q <= 1'b0;
          end
        end
        st_addr:
        begin
          if (ar_ready_i)
          begin
            state_q <= st_wait;
          end
        end
        default:
        begin
          if (r_valid_i)
          begin
            state_q <= st_idle;
          end
        end
      endcase
      // Redirect while a read is out: still fill, never report.
      if (flush_i && state_q != st_idle)
      begin
        stale_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == st_idle && miss_i)
    begin
      addr_q <= miss_addr_i;
    end
  end

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl #(
  parameter int                          CREDITS  = 4,
  parameter logic [fetch_pkg::addr_w-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          redirect_i,
  input  logic [fetch_pkg::addr_w-1:0]  redirect_pc_i,
  input  logic                          credit_i,
  output fetch_pkg::lookup_req_t        req_o,
  input  logic                          hit_i,
  input  logic [fetch_pkg::data_w-1:0]  hit_data_i,
  output logic                          miss_o,
  output logic                          flush_o,
  input  fetch_pkg::fill_t              fill_i,
  input  logic                          fill_live_i,
  output logic                          pkt_valid_o,
  output fetch_pkg::fetch_pkt_t         pkt_o
);
  import fetch_pkg::*;

  localparam int cnt_w = $clog2(CREDITS + 1);

  logic [addr_w-1:0] pc_q;
  logic              req_valid_q;
  logic              wait_fill_q;
  logic [cnt_w-1:0]  credit_q;
  logic              pkt_valid_q;
  fetch_pkt_t        pkt_q;

  logic             hit_fire;
  logic             fill_fire;
  logic             pkt_fire;
  logic             wait_fill_nxt;
  logic [cnt_w-1:0] credit_nxt;
  logic             issue;

  // A redirect cancels whatever result lands in its cycle.
  assign hit_fire = req_valid_q & hit_i & ~redirect_i;
  assign fill_fire = wait_fill_q & fill_i.valid & fill_live_i & ~redirect_i;
  assign pkt_fire = hit_fire | fill_fire;

  assign miss_o = req_valid_q & ~hit_i & ~redirect_i;
  assign flush_o = redirect_i;

  // Any outstanding read, stale or not, blocks the next lookup.
  assign wait_fill_nxt = (wait_fill_q & ~fill_i.valid) | miss_o;

  assign credit_nxt = credit_q - cnt_w'(pkt_fire) + cnt_w'(credit_i);

  // One lookup in flight; needs a credit left after this cycle's packet.
  assign issue = ~wait_fill_nxt & (credit_nxt != '0);

  assign req_o.valid = req_valid_q;
  assign req_o.addr = pc_q;

  assign pkt_valid_o = pkt_valid_q;
  assign pkt_o = pkt_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
      req_valid_q <= 1'b0;
      wait_fill_q <= 1'b0;
      credit_q <= cnt_w'(CREDITS);
      pkt_valid_q <= 1'b0;
    end
    else
    begin
      req_valid_q <= issue;
      wait_fill_q <= wait_fill_nxt;
      credit_q <= credit_nxt;
      pkt_valid_q <= pkt_fire;
      if (redirect_i)
      begin
        pc_q <= redirect_pc_i;
      end
      else if (pkt_fire)
      begin
        pc_q <= pc_q + addr_w'(inst_bytes);
      end
    end
  end

  // Packet payload.
  always_ff @(posedge clk)
  begin
    if (pkt_fire)
    begin
      pkt_q.pc <= pc_q;
      pkt_q.inst <= hit_fire ? hit_data_i : fill_i.data;
    end
  end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
  parameter int                          SETS     = 16,
  parameter int                          CREDITS  = 4,
  parameter logic [fetch_pkg::addr_w-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          redirect_i,
  input  logic [fetch_pkg::addr_w-1:0]  redirect_pc_i,
  output logic                          pkt_valid_o,
  output fetch_pkg::fetch_pkt_t         pkt_o,
  input  logic                          credit_i,
  output logic                          ar_valid_o,
  output logic [fetch_pkg::addr_w-1:0]  ar_addr_o,
  input  logic                          ar_ready_i,
  input  logic                          r_valid_i,
  input  logic [fetch_pkg::data_w-1:0]  r_data_i
);
  import fetch_pkg::*;

  lookup_req_t       req;
  logic              hit;
  logic [data_w-1:0] hit_data;
  logic              miss;
  logic              flush;
  fill_t             fill;
  logic              fill_live;

  fetch_ctrl #(
    .CREDITS  (CREDITS),
    .RESET_PC (RESET_PC)
  ) fetch_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .credit_i      (credit_i),
    .req_o         (req),
    .hit_i         (hit),
    .hit_data_i    (hit_data),
    .miss_o        (miss),
    .flush_o       (flush),
    .fill_i        (fill),
    .fill_live_i   (fill_live),
    .pkt_valid_o   (pkt_valid_o),
    .pkt_o         (pkt_o)
  );

  l1i_cache #(
    .SETS (SETS)
  ) l1i_cache_inst (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req),
    .fill_i     (fill),
    .hit_o      (hit),
    .hit_data_o (hit_data)
  );

  bus_fetcher bus_fetcher_inst (
    .clk         (clk),
    .rst         (rst),
    .miss_i      (miss),
    .miss_addr_i (req.addr),
    .flush_i     (flush),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .fill_o      (fill),
    .fill_live_o (fill_live)
  );

endmodule

/* fetch_mem_model.sv */
`timescale 1ns/1ps

module fetch_mem_model (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          ar_valid_i,
  input  logic [fetch_pkg::addr_w-1:0]  ar_addr_i,
  output logic                          ar_ready_o,
  output logic                          r_valid_o,
  output logic [fetch_pkg::data_w-1:0]  r_data_o
);
  import fetch_pkg::*;

  int                seed = 32'hb07ccf81;
  logic              ready_q = 1'b0;
  logic              rvalid_q = 1'b0;
  logic [data_w-1:0] rdata_q = '0;
  logic              pending_q = 1'b0;
  logic [addr_w-1:0] addr_q = '0;
  int                wait_q = 0;

  // Memory contents, a hash of the full address.
  function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
    logic [31:0] mix;
    mix = addr * 32'h9e37_79b1;
    return mix ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  assign ar_ready_o = ready_q;
  assign r_valid_o = rvalid_q;
  assign r_data_o = rdata_q;

  always @(posedge clk)
  begin
    if (rst)
    begin
      ready_q <= 1'b0;
      rvalid_q <= 1'b0;
      pending_q <= 1'b0;
      wait_q <= 0;
    end
    else
    begin
      rvalid_q <= 1'b0;
      if (ar_valid_i && ready_q)
      begin
        pending_q <= 1'b1;
        addr_q <= ar_addr_i;
        wait_q <= rand_below(8);
        ready_q <= 1'b0;
      end
      else if (pending_q)
      begin
        // Single-cycle data pulse after the latency expires.
        if (wait_q == 0)
        begin
          rvalid_q <= 1'b1;
          rdata_q <= mem_word(addr_q);
          pending_q <= 1'b0;
          wait_q <= rand_below(4);
        end
        else
        begin
          wait_q <= wait_q - 1;
        end
      end
      else if (wait_q == 0)
      begin
        ready_q <= 1'b1;
      end
      else
      begin
        wait_q <= wait_q - 1;
      end
    end
  end

endmodule

/* fetch_assert.sv */
`timescale 1ns/1ps

module fetch_assert #(
  parameter int CREDITS = 4
) (
  input logic                          clk,
  input logic                          rst,
  input logic                          pkt_valid_i,
  input logic                          credit_i,
  input logic                          ar_valid_i,
  input logic [fetch_pkg::addr_w-1:0]  ar_addr_i,
  input logic                          ar_ready_i
);

  // Packets seen minus credits seen.
  int unsettled_q;
  // Assertion failures so far.
  int fail_count = 0;

  always @(posedge clk)
  begin
    if (rst)
    begin
      unsettled_q <= 0;
    end
    else
    begin
      unsettled_q <= unsettled_q + int'(pkt_valid_i) - int'(credit_i);
    end
  end

  ar_hold_stable: assert property (@(posedge clk) disable iff (rst)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
  else
  begin
    $error("Read address channel changed before ready.");
    fail_count = fail_count + 1;
  end

  pkt_needs_credit: assert property (@(posedge clk) disable iff (rst)
    pkt_valid_i |-> unsettled_q < CREDITS)
  else
  begin
    $error("Packet delivered with no credit held.");
    fail_count = fail_count + 1;
  end

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !pkt_valid_i && !ar_valid_i)
  else
  begin
    $error("Outputs active right after reset.");
    fail_count = fail_count + 1;
  end

endmodule

bind fetch_top fetch_assert #(
  .CREDITS (CREDITS)
) fetch_assert_inst (
  .clk         (clk),
  .rst         (rst),
  .pkt_valid_i (pkt_valid_o),
  .credit_i    (credit_i),
  .ar_valid_i  (ar_valid_o),
  .ar_addr_i   (ar_addr_o),
  .ar_ready_i  (ar_ready_i)
);

/* fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int                sets = 16;
  localparam int                credits = 4;
  localparam logic [addr_w-1:0] reset_pc = 32'h8000_0000;
  localparam int                period_ns = 100;
  // Worst case per packet of ready gap, read latency, credit delay and slack.
  localparam int                worst_cycles = 40;
  localparam int                total_pkts = 64 + sets + 8 + 3 + 4 * credits;
  localparam int                timeout_ns = (total_pkts * worst_cycles + 200) * period_ns;

  logic              clk = 1'b0;
  logic              rst;
  logic              redirect_i;
  logic [addr_w-1:0] redirect_pc_i;
  logic              credit_i = 1'b0;
  logic              pkt_valid_o;
  fetch_pkt_t        pkt_o;
  logic              ar_valid_o;
  logic [addr_w-1:0] ar_addr_o;
  logic              ar_ready_i;
  logic              r_valid_i;
  logic [data_w-1:0] r_data_i;

  int                seed = 32'hb07ccf81;
  string             test_name = "reset";
  logic              hold_credits = 1'b0;
  logic [addr_w-1:0] exp_pc = reset_pc;
  int                pkts_seen = 0;
  int                since_redirect = 0;
  int                credits_sent = 0;
  int                credits_back = 0;
  int                credit_wait = 0;
  int                ar_count [logic [addr_w-1:0]];

  fetch_top #(
    .SETS     (sets),
    .CREDITS  (credits),
    .RESET_PC (reset_pc)
  ) fetch_top_inst (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pkt_valid_o   (pkt_valid_o),
    .pkt_o         (pkt_o),
    .credit_i      (credit_i),
    .ar_valid_o    (ar_valid_o),
    .ar_addr_o     (ar_addr_o),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i)
  );

  fetch_mem_model mem_model_inst (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid_o),
    .ar_addr_i  (ar_addr_o),
    .ar_ready_o (ar_ready_i),
    .r_valid_o  (r_valid_i),
    .r_data_o   (r_data_i)
  );

  // Reference memory contents.
  function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
    logic [31:0] mix;
    mix = addr * 32'h9e37_79b1;
    return mix ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic int reads_of(input logic [addr_w-1:0] addr);
    if (ar_count.exists(addr))
    begin
      return ar_count[addr];
    end
    return 0;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else report_failure($sformatf("[ERROR] %s: %s expected %h actual %h",
                                  test_name, what, exp, act));
  endtask

  // Called on a clock edge; returns once the checker has seen the redirect.
  task automatic redirect_to(input logic [addr_w-1:0] pc);
    redirect_i <= 1'b1;
    redirect_pc_i <= pc;
    @(posedge clk);
    redirect_i <= 1'b0;
    @(posedge clk);
  endtask

  task automatic wait_after_redirect(input int n);
    while (since_redirect < n)
    begin
      @(posedge clk);
    end
  endtask

  initial
  begin
    forever #(period_ns / 2) clk = ~clk;
  end

  initial
  begin
    #(timeout_ns);
    report_failure("Watchdog timeout: the fetch unit stopped delivering packets.");
  end

  // Checker, bus read counter and credit return.
  always @(posedge clk)
  begin
    assert (fetch_top_inst.fetch_assert_inst.fail_count == 0)
    else report_failure("A protocol assertion on the fetch unit fired.");
    if (!rst)
    begin
      if (pkt_valid_o)
      begin
        check_value("packet pc", exp_pc, pkt_o.pc);
        check_value("packet inst", mem_word(exp_pc), pkt_o.inst);
        assert (pkts_seen + 1 - credits_back <= credits)
        else report_failure("More packets outstanding than decode credits.");
        pkts_seen <= pkts_seen + 1;
        since_redirect <= since_redirect + 1;
        exp_pc <= exp_pc + 32'd4;
      end
      if (redirect_i)
      begin
        exp_pc <= redirect_pc_i;
        since_redirect <= 0;
      end
      if (credit_i)
      begin
        credits_back <= credits_back + 1;
      end
      if (ar_valid_o && ar_ready_i)
      begin
        ar_count[ar_addr_o] = reads_of(ar_addr_o) + 1;
      end
      credit_i <= 1'b0;
      if (credit_wait > 0)
      begin
        credit_wait <= credit_wait - 1;
      end
      else if (!hold_credits && !credit_i && pkts_seen > credits_sent)
      begin
        credit_i <= 1'b1;
        credits_sent <= credits_sent + 1;
        credit_wait <= rand_below(4);
      end
    end
  end

  initial
  begin
    logic [addr_w-1:0] base;
    logic [addr_w-1:0] alias_a;
    logic [addr_w-1:0] alias_b;
    int                snap [sets];
    int                frozen;
    rst = 1'b1;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    test_name <= "sequential";
    while (pkts_seen < 64)
    begin
      @(posedge clk);
    end

    // Withhold credits until the unit stalls.
    test_name <= "backpressure";
    hold_credits <= 1'b1;
    while (pkts_seen - credits_back < credits)
    begin
      @(posedge clk);
    end
    frozen = pkts_seen;
    repeat (30) @(posedge clk);
    check_value("packets while stalled", frozen, pkts_seen);

    // Last sets words are all resident while stalled.
    test_name <= "cache_reuse";
    base = exp_pc - addr_w'(4 * sets);
    @(negedge clk);
    for (int i = 0; i < sets; i++)
    begin
      snap[i] = reads_of(base + 4 * i);
      check_value("earlier bus reads", 1, snap[i]);
    end
    @(posedge clk);
    redirect_to(base);
    hold_credits <= 1'b0;
    wait_after_redirect(sets);
    @(negedge clk);
    for (int i = 0; i < sets; i++)
    begin
      check_value("bus reads of cached word", snap[i], reads_of(base + 4 * i));
    end

    // Cancelled address would break the pc sequence in the checker.
    test_name <= "miss_redirect";
    @(posedge clk);
    while (!ar_valid_o)
    begin
      @(posedge clk);
    end
    redirect_to(reset_pc + 32'h0000_4000);
    wait_after_redirect(8);

    test_name <= "index_alias";
    alias_a = 32'h0002_0000;
    alias_b = alias_a + addr_w'(4 * sets);
    redirect_to(alias_a);
    wait_after_redirect(1);
    redirect_to(alias_b);
    wait_after_redirect(1);
    redirect_to(alias_a);
    wait_after_redirect(1);
    @(negedge clk);
    check_value("bus reads of first alias", 2, reads_of(alias_a));
    check_value("bus reads of second alias", 1, reads_of(alias_b));

    @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

/* all.f */
fetch_pkg.sv
l1i_cache.sv
bus_fetcher.sv
fetch_ctrl.sv
fetch_top.sv
fetch_mem_model.sv
fetch_assert.sv
fetch_tb.sv

/* Makefile */
TOP = fetch_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP) -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
